// ==== Bender.yml ====
package:
  name: ebi_subsystem

sources:
  - files:
      - rtl/ebi_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/time_base.sv
      - rtl/ebi_bus_ctrl.sv
      - rtl/ebi_subsystem.sv
  - target: test
    files:
      - test/tb_clkgen.sv
      - test/ebi_sva.sv
      - test/tb_ebi.sv

// ==== rtl/ebi_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebi_bus_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  input  ebi_pkg::ebi_req_t                    req,
  output logic [ebi_pkg::DATA_W-1:0]           rdata,
  output ebi_pkg::cmd_word_t                   cmd,
  output logic                                 cmd_push,
  input  ebi_pkg::fifo_flags_t                 cmd_flags,
  input  logic [ebi_pkg::CMD_COUNT_W-1:0]      cmd_count,
  input  ebi_pkg::sample_t                     sample_data,
  output logic                                 sample_pop,
  input  ebi_pkg::fifo_flags_t                 sample_flags,
  input  logic [ebi_pkg::SAMPLE_COUNT_W-1:0]   sample_count,
  input  logic [ebi_pkg::TIME_W-1:0]           time_now,
  output logic                                 time_run,
  output logic                                 time_clear,
  output logic                                 irq
);

  typedef enum logic [4:0] {
    st_fetch          = 5'b00001,
    st_cmd_done       = 5'b00010,
    st_sample_read    = 5'b00100,
    st_sample_capture = 5'b01000,
    st_time_cmd       = 5'b10000
  } state_t;

  state_t                       state;
  state_t                       state_next;
  logic                         wr_stb;
  logic                         rd_stb;
  logic                         wr_d;
  logic                         wr_dd;
  logic                         rd_d;
  logic                         rd_dd;
  logic                         wr_done;
  logic                         rd_done;
  logic                         cmd_push_next;
  logic                         sample_pop_next;
  logic                         time_run_next;
  logic                         time_clear_next;
  logic                         capture_q;
  logic [ebi_pkg::DATA_W-1:0]   time_cmd_q;
  logic [ebi_pkg::DATA_W-1:0]   last_word_q;
  logic [ebi_pkg::DATA_W-1:0]   sample_hold_q;
  logic [ebi_pkg::DATA_W-1:0]   status_q;
  logic [ebi_pkg::DATA_W-1:0]   rdata_mux;

  assign wr_stb = req.cs & req.wr;
  assign rd_stb = req.cs & req.rd;

  // strobe fell two samples ago
  assign wr_done = ~wr_d & wr_dd;
  assign rd_done = ~rd_d & rd_dd;

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  always_comb begin
    state_next      = state;
    cmd_push_next   = 1'b0;
    sample_pop_next = 1'b0;
    time_run_next   = 1'b0;
    time_clear_next = 1'b0;
    case (state)
      st_fetch: begin
        if (wr_stb) begin
          if (req.addr == ebi_pkg::ADDR_CMD_WORD_5) begin
            state_next = st_cmd_done;
          end else if (req.addr == ebi_pkg::ADDR_TIME_CMD) begin
            state_next = st_time_cmd;
          end
        end else if (rd_stb && req.addr == ebi_pkg::ADDR_NEXT_SAMPLE) begin
          state_next = st_sample_read;
        end
      end
      st_cmd_done: begin
        if (wr_done) begin
          state_next    = st_fetch;
          cmd_push_next = 1'b1;
        end
      end
      st_sample_read: begin
        // host has the hold value, fetch the next one
        if (rd_done) begin
          state_next      = st_sample_capture;
          sample_pop_next = 1'b1;
        end
      end
      st_sample_capture: begin
        state_next = st_fetch;
      end
      st_time_cmd: begin
        if (wr_done) begin
          state_next = st_fetch;
          if (time_cmd_q == ebi_pkg::TIME_CMD_CLEAR) begin
            time_clear_next = 1'b1;
          end else if (time_cmd_q == ebi_pkg::TIME_CMD_RUN) begin
            time_run_next = 1'b1;
          end
        end
      end
      default: state_next = st_fetch;
    endcase
  end

  // read data source by address
  always_comb begin
    case (req.addr)
      ebi_pkg::ADDR_STATUS:       rdata_mux = status_q;
      ebi_pkg::ADDR_NEXT_SAMPLE:  rdata_mux = sample_hold_q;
      ebi_pkg::ADDR_TIME_LOW:     rdata_mux = time_now[15:0];
      ebi_pkg::ADDR_TIME_HIGH:    rdata_mux = time_now[31:16];
      ebi_pkg::ADDR_SAMPLE_COUNT: begin
        rdata_mux = {{(ebi_pkg::DATA_W - ebi_pkg::SAMPLE_COUNT_W){1'b0}}, sample_count};
      end
      ebi_pkg::ADDR_READBACK:     rdata_mux = last_word_q;
      ebi_pkg::ADDR_CMD_COUNT: begin
        rdata_mux = {{(ebi_pkg::DATA_W - ebi_pkg::CMD_COUNT_W){1'b0}}, cmd_count};
      end
      default:                    rdata_mux = '0;
    endcase
  end

  // ----------------------------------------
  // control and status registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= st_fetch;
      cmd_push      <= 1'b0;
      sample_pop    <= 1'b0;
      time_run      <= 1'b0;
      time_clear    <= 1'b0;
      capture_q     <= 1'b0;
      wr_d          <= 1'b0;
      wr_dd         <= 1'b0;
      rd_d          <= 1'b0;
      rd_dd         <= 1'b0;
      status_q      <= '0;
      irq           <= 1'b0;
      rdata         <= '0;
      sample_hold_q <= ebi_pkg::SAMPLE_IDLE_VALUE;
    end else begin
      state      <= state_next;
      cmd_push   <= cmd_push_next;
      sample_pop <= sample_pop_next;
      time_run   <= time_run_next;
      time_clear <= time_clear_next;
      // fifo head is valid one cycle after the pop
      capture_q  <= (state == st_sample_capture);
      wr_d       <= wr_stb;
      wr_dd      <= wr_d;
      rd_d       <= rd_stb;
      rd_dd      <= rd_d;
      status_q   <= {cmd_flags.almost_full, cmd_flags.full,
                     cmd_flags.almost_empty, cmd_flags.empty,
                     sample_flags.almost_full, sample_flags.full,
                     sample_flags.empty, sample_flags.almost_empty,
                     8'h00};
      irq        <= status_q[14] | status_q[10];
      if (capture_q) begin
        sample_hold_q <= sample_data;
      end
      // first edge of a read only
      if (rd_stb && !rd_d) begin
        rdata <= rdata_mux;
      end
    end
  end

  // register bank for writes
  always_ff @(posedge clk) begin
    if (wr_stb) begin
      last_word_q <= req.wdata;
      case (req.addr)
        ebi_pkg::ADDR_CMD_WORD_1: cmd.w1     <= req.wdata;
        ebi_pkg::ADDR_CMD_WORD_2: cmd.w2     <= req.wdata;
        ebi_pkg::ADDR_CMD_WORD_3: cmd.w3     <= req.wdata;
        ebi_pkg::ADDR_CMD_WORD_4: cmd.w4     <= req.wdata;
        ebi_pkg::ADDR_CMD_WORD_5: cmd.w5     <= req.wdata;
        ebi_pkg::ADDR_TIME_CMD:   time_cmd_q <= req.wdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ebi_pkg.sv ====
`default_nettype none

package ebi_pkg;

  // ----------------------------------------
  // bus and datapath widths
  // ----------------------------------------
  localparam int DATA_W = 16;
  localparam int ADDR_W = 8;
  localparam int TIME_W = 32;

  // register map
  localparam logic [ADDR_W-1:0] ADDR_STATUS       = 8'd0;
  localparam logic [ADDR_W-1:0] ADDR_CMD_WORD_1   = 8'd1;
  localparam logic [ADDR_W-1:0] ADDR_CMD_WORD_2   = 8'd2;
  localparam logic [ADDR_W-1:0] ADDR_CMD_WORD_3   = 8'd3;
  localparam logic [ADDR_W-1:0] ADDR_CMD_WORD_4   = 8'd4;
  localparam logic [ADDR_W-1:0] ADDR_CMD_WORD_5   = 8'd5;
  localparam logic [ADDR_W-1:0] ADDR_NEXT_SAMPLE  = 8'd6;
  localparam logic [ADDR_W-1:0] ADDR_TIME_CMD     = 8'd7;
  localparam logic [ADDR_W-1:0] ADDR_TIME_LOW     = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_TIME_HIGH    = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_SAMPLE_COUNT = 8'd11;
  localparam logic [ADDR_W-1:0] ADDR_READBACK     = 8'd12;
  localparam logic [ADDR_W-1:0] ADDR_CMD_COUNT    = 8'd13;

  // magic words written to ADDR_TIME_CMD
  localparam logic [DATA_W-1:0] TIME_CMD_RUN   = 16'hDEAD;
  localparam logic [DATA_W-1:0] TIME_CMD_CLEAR = 16'hBEEF;

  // sample hold value before the first pop
  localparam logic [DATA_W-1:0] SAMPLE_IDLE_VALUE = 16'hDEAD;

  // ----------------------------------------
  // fifo sizing
  // ----------------------------------------
  localparam int CMD_FIFO_DEPTH    = 16;
  localparam int SAMPLE_FIFO_DEPTH = 32;
  localparam int ALMOST_MARGIN     = 2;
  localparam int CMD_COUNT_W       = 5;
  localparam int SAMPLE_COUNT_W    = 6;

  // host bus request, all levels
  typedef struct packed {
    logic              cs;
    logic              rd;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } ebi_req_t;

  // one command, w1 is the most significant word
  typedef struct packed {
    logic [DATA_W-1:0] w1;
    logic [DATA_W-1:0] w2;
    logic [DATA_W-1:0] w3;
    logic [DATA_W-1:0] w4;
    logic [DATA_W-1:0] w5;
  } cmd_word_t;

  typedef struct packed {
    logic almost_full;
    logic full;
    logic almost_empty;
    logic empty;
  } fifo_flags_t;

  typedef logic [DATA_W-1:0] sample_t;

endpackage

`default_nettype wire

// ==== rtl/ebi_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebi_subsystem (
  input  logic                          clk,
  input  logic                          rst,
  input  ebi_pkg::ebi_req_t             ebi_req,
  output logic [ebi_pkg::DATA_W-1:0]    ebi_rdata,
  input  logic                          sample_push,
  input  ebi_pkg::sample_t              sample_in,
  input  logic                          cmd_pop,
  output ebi_pkg::cmd_word_t            cmd_out,
  output logic [ebi_pkg::TIME_W-1:0]    time_now,
  output logic                          irq
);

  ebi_pkg::cmd_word_t                    cmd_word;
  logic                                  cmd_push;
  ebi_pkg::fifo_flags_t                  cmd_flags;
  logic [ebi_pkg::CMD_COUNT_W-1:0]       cmd_count;
  ebi_pkg::sample_t                      sample_data;
  logic                                  sample_pop;
  ebi_pkg::fifo_flags_t                  sample_flags;
  logic [ebi_pkg::SAMPLE_COUNT_W-1:0]    sample_count;
  logic                                  time_run;
  logic                                  time_clear;

  ebi_bus_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (ebi_req),
    .rdata        (ebi_rdata),
    .cmd          (cmd_word),
    .cmd_push     (cmd_push),
    .cmd_flags    (cmd_flags),
    .cmd_count    (cmd_count),
    .sample_data  (sample_data),
    .sample_pop   (sample_pop),
    .sample_flags (sample_flags),
    .sample_count (sample_count),
    .time_now     (time_now),
    .time_run     (time_run),
    .time_clear   (time_clear),
    .irq          (irq)
  );

  time_base u_time (
    .clk      (clk),
    .rst      (rst),
    .run      (time_run),
    .clear    (time_clear),
    .time_now (time_now)
  );

  // ----------------------------------------
  // host to consumer commands
  // ----------------------------------------
  sync_fifo #(
    .payload_t (ebi_pkg::cmd_word_t),
    .DEPTH     (ebi_pkg::CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_push),
    .push_data (cmd_word),
    .pop       (cmd_pop),
    .pop_data  (cmd_out),
    .flags     (cmd_flags),
    .count     (cmd_count)
  );

  // acquisition samples to host
  sync_fifo #(
    .payload_t (ebi_pkg::sample_t),
    .DEPTH     (ebi_pkg::SAMPLE_FIFO_DEPTH)
  ) u_sample_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (sample_push),
    .push_data (sample_in),
    .pop       (sample_pop),
    .pop_data  (sample_data),
    .flags     (sample_flags),
    .count     (sample_count)
  );

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH     = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  payload_t                     push_data,
  input  logic                         pop,
  output payload_t                     pop_data,
  output ebi_pkg::fifo_flags_t         flags,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              do_push;
  logic              do_pop;

  // full drops the push, empty drops the pop
  assign do_push = push && !flags.full;
  assign do_pop  = pop && !flags.empty;

  // pointer, count and flag state
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and head register
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  assign flags.full         = (count == CNT_W'(DEPTH));
  assign flags.empty        = (count == '0);
  assign flags.almost_full  = (count >= CNT_W'(DEPTH - ebi_pkg::ALMOST_MARGIN));
  assign flags.almost_empty = (count <= CNT_W'(ebi_pkg::ALMOST_MARGIN));

endmodule

`default_nettype wire

// ==== rtl/time_base.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_base (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run,
  input  logic                        clear,
  output logic [ebi_pkg::TIME_W-1:0]  time_now
);

  logic                        running;
  logic [ebi_pkg::TIME_W-1:0]  counter;

  // ----------------------------------------
  // run flag and counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      counter <= '0;
    end else begin
      if (clear) begin
        // clear also stops time
        counter <= '0;
        running <= 1'b0;
      end else begin
        if (running) begin
          counter <= counter + 1'b1;
        end
        // count begins on the cycle after run
        if (run) begin
          running <= 1'b1;
        end
      end
    end
  end

  assign time_now = counter;

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/ebi_pkg.sv
rtl/sync_fifo.sv
rtl/time_base.sv
rtl/ebi_bus_ctrl.sv
rtl/ebi_subsystem.sv
test/tb_clkgen.sv
test/ebi_sva.sv
test/tb_ebi.sv

// ==== test/ebi_cases.txt ====
# all operands hex: W addr data, R addr expect, S first n, N first n, Q level, T
# P w1 w2 w3 w4 w5 expects one pop, K base n writes n commands, D base n pops them
R 0 3300
S a001 3
R b 0003
R 6 dead
R 6 a001
R 6 a002
R 6 a003
R 6 a003
W 1 1111
W 2 2222
W 3 3333
W 4 4444
W 5 5555
P 1111 2222 3333 4444 5555
R d 0000
K 2000 2
R d 0002
D 2000 2
W 14 5a5a
R c 5a5a
W 7 beef
R 9 0000
R a 0000
W 7 dead
T
S 0100 20
Q 1
R 0 3c00
R 6 a003
N 0100 1f
Q 0
R 0 3300
K 1000 11
R d 0010
Q 1
D 1000 10
R d 0000
Q 0

// ==== test/ebi_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebi_sva (
  input logic clk,
  input logic rst,
  input logic cmd_push,
  input logic sample_pop,
  input logic time_run,
  input logic time_clear
);

  // ----------------------------------------
  // single-cycle control pulses
  // ----------------------------------------
  a_cmd_push_pulse: assert property (@(posedge clk) disable iff (rst) cmd_push |=> !cmd_push)
    else $error("cmd_push stayed high for more than one cycle");

  a_sample_pop_pulse: assert property (@(posedge clk) disable iff (rst)
    sample_pop |=> !sample_pop)
    else $error("sample_pop stayed high for more than one cycle");

  a_time_run_pulse: assert property (@(posedge clk) disable iff (rst) time_run |=> !time_run)
    else $error("time_run stayed high for more than one cycle");

  a_time_clear_pulse: assert property (@(posedge clk) disable iff (rst)
    time_clear |=> !time_clear)
    else $error("time_clear stayed high for more than one cycle");

  // run and clear come from one write, never both
  a_run_clear_excl: assert property (@(posedge clk) disable iff (rst) !(time_run && time_clear))
    else $error("time_run and time_clear high together");

endmodule

bind ebi_bus_ctrl ebi_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .cmd_push   (cmd_push),
  .sample_pop (sample_pop),
  .time_run   (time_run),
  .time_clear (time_clear)
);

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // 8 ns period
  always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== test/tb_ebi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ebi;

  logic                clk;
  logic                rst;
  ebi_pkg::ebi_req_t   req;
  logic [15:0]         rdata;
  logic                sample_push;
  ebi_pkg::sample_t    sample_in;
  logic                cmd_pop;
  ebi_pkg::cmd_word_t  cmd_out;
  logic [31:0]         time_now;
  logic                irq;
  integer              fd;

  tb_clkgen u_clkgen (
    .clk (clk)
  );

  ebi_subsystem dut0 (
    .clk         (clk),
    .rst         (rst),
    .ebi_req     (req),
    .ebi_rdata   (rdata),
    .sample_push (sample_push),
    .sample_in   (sample_in),
    .cmd_pop     (cmd_pop),
    .cmd_out     (cmd_out),
    .time_now    (time_now),
    .irq         (irq)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [79:0] actual, input logic [79:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0t ns: %s: got %h, expected %h",
                          $time, what, actual, expected));
    end
  endtask

  task automatic check_operands(input integer got, input integer want);
    if (got != want) begin
      abort_run("malformed line in the case file, operands missing");
    end
  endtask

  // command i of a burst, word j is base + 16*i + j
  function automatic ebi_pkg::cmd_word_t command_pattern(input logic [15:0] base,
                                                         input int idx);
    ebi_pkg::cmd_word_t c;
    c.w1 = base + 16'(idx * 16) + 16'd1;
    c.w2 = base + 16'(idx * 16) + 16'd2;
    c.w3 = base + 16'(idx * 16) + 16'd3;
    c.w4 = base + 16'(idx * 16) + 16'd4;
    c.w5 = base + 16'(idx * 16) + 16'd5;
    return c;
  endfunction

  // ----------------------------------------
  // host bus cycles
  // ----------------------------------------
  task automatic bus_cycle(input logic is_write, input logic [7:0] addr,
                           input logic [15:0] data, output logic [15:0] value);
    @(negedge clk);
    req.cs    = 1'b1;
    req.rd    = ~is_write;
    req.wr    = is_write;
    req.addr  = addr;
    req.wdata = data;
    repeat (2) @(negedge clk);
    value  = rdata;
    req.cs = 1'b0;
    req.rd = 1'b0;
    req.wr = 1'b0;
    // done pulse and hold update land in this gap
    repeat (4) @(negedge clk);
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    logic [15:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic bus_read_check(input logic [7:0] addr, input logic [15:0] expected);
    logic [15:0] value;
    bus_cycle(1'b0, addr, 16'h0000, value);
    check_value(value, expected, $sformatf("read of address %h", addr));
  endtask

  task automatic push_samples(input logic [15:0] first, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      sample_push = 1'b1;
      sample_in   = first + 16'(i);
    end
    @(negedge clk);
    sample_push = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic read_samples(input logic [15:0] first, input int n);
    for (int i = 0; i < n; i++) begin
      bus_read_check(ebi_pkg::ADDR_NEXT_SAMPLE, first + 16'(i));
    end
  endtask

  task automatic pop_command(input ebi_pkg::cmd_word_t expected);
    @(negedge clk);
    cmd_pop = 1'b1;
    @(negedge clk);
    cmd_pop = 1'b0;
    @(negedge clk);
    check_value(cmd_out, expected, "popped command");
  endtask

  task automatic write_commands(input logic [15:0] base, input int n);
    ebi_pkg::cmd_word_t c;
    for (int i = 0; i < n; i++) begin
      c = command_pattern(base, i);
      bus_write(ebi_pkg::ADDR_CMD_WORD_1, c.w1);
      bus_write(ebi_pkg::ADDR_CMD_WORD_2, c.w2);
      bus_write(ebi_pkg::ADDR_CMD_WORD_3, c.w3);
      bus_write(ebi_pkg::ADDR_CMD_WORD_4, c.w4);
      bus_write(ebi_pkg::ADDR_CMD_WORD_5, c.w5);
    end
  endtask

  task automatic pop_commands(input logic [15:0] base, input int n);
    for (int i = 0; i < n; i++) begin
      pop_command(command_pattern(base, i));
    end
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    while (irq !== level && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (irq !== level) begin
      abort_run($sformatf("timeout while waiting for irq to go to %0d", level));
    end
  endtask

  task automatic check_time_running();
    logic [15:0] t1;
    logic [15:0] t2;
    bus_cycle(1'b0, ebi_pkg::ADDR_TIME_LOW, 16'h0000, t1);
    repeat (6) @(negedge clk);
    bus_cycle(1'b0, ebi_pkg::ADDR_TIME_LOW, 16'h0000, t2);
    check_value(t2 > t1, 1'b1, "time base increasing between reads");
    check_value(time_now != 32'd0, 1'b1, "time_now nonzero while running");
  endtask

  // clear a running time base, both halves and the port drop to zero
  task automatic check_time_clear();
    bus_write(ebi_pkg::ADDR_TIME_CMD, ebi_pkg::TIME_CMD_CLEAR);
    bus_read_check(ebi_pkg::ADDR_TIME_LOW, 16'h0000);
    bus_read_check(ebi_pkg::ADDR_TIME_HIGH, 16'h0000);
    check_value(time_now, 80'd0, "time_now after clear");
  endtask

  // ----------------------------------------
  // case file interpreter
  // ----------------------------------------
  task automatic run_cases();
    logic [63:0]   op;
    logic [1279:0] rest;
    logic [15:0]   a;
    logic [15:0]   b;
    logic [15:0]   w [5];
    integer        code;
    int            lines;
    bit            done;
    lines = 0;
    done  = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %s", op);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        lines++;
        if (lines > 400) begin
          abort_run("case file has too many entries, giving up");
        end
        case (op)
          "#": code = $fgets(rest, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            bus_write(a[7:0], b);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            bus_read_check(a[7:0], b);
          end
          "S": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            push_samples(a, int'(b));
          end
          "N": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            read_samples(a, int'(b));
          end
          "P": begin
            code = $fscanf(fd, "%h %h %h %h %h", w[0], w[1], w[2], w[3], w[4]);
            check_operands(code, 5);
            pop_command({w[0], w[1], w[2], w[3], w[4]});
          end
          "K": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            write_commands(a, int'(b));
          end
          "D": begin
            code = $fscanf(fd, "%h %h", a, b);
            check_operands(code, 2);
            pop_commands(a, int'(b));
          end
          "Q": begin
            code = $fscanf(fd, "%h", a);
            check_operands(code, 1);
            wait_irq(a[0]);
          end
          "T": begin
            check_time_running();
            check_time_clear();
          end
          default: abort_run($sformatf("unknown opcode %0s in the case file", op));
        endcase
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    req         = '0;
    sample_push = 1'b0;
    sample_in   = '0;
    cmd_pop     = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    fd = $fopen("test/ebi_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open test/ebi_cases.txt");
    end
    run_cases();
    $fclose(fd);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
